//--- tests/decodeTrace.txt
# instr valid stall | expected fc rfw isLoad isStore hasImm Rt Ra Rb imm (all hex)
# Expected columns are the decode of the word, used only when the line is taken
0000000B 0 0 0 0 0 0 0 00 00 00 00000000
0A184082 1 0 0 1 0 0 0 01 02 03 00000000
0918A204 1 0 0 1 0 0 1 04 05 00 00000123
FFF8E308 1 0 0 1 0 0 1 06 07 00 FFFFFFFF
8007F009 1 0 0 1 0 0 1 20 3F 00 FFFFF000
7FF92440 1 0 0 1 1 0 1 08 09 00 00000FFF
FF816550 1 0 0 0 0 1 1 00 0A 0B FFFFFFF0
FFFFFF8B 1 0 0 0 0 0 0 00 00 00 00000000
12345680 1 0 1 0 0 0 0 00 00 00 00000000
02019F83 1 0 1 1 0 0 1 3F 0C 00 00000040
C002BFEA 1 0 1 1 0 0 1 3F 00 00 FFFFF800
004040EB 1 0 1 0 0 0 1 00 01 02 00000008
FFF008DF 1 0 1 0 0 0 1 00 11 00 FFFFFFFE
00826960 1 0 1 0 0 0 1 00 12 13 00000010
00826961 1 0 1 0 0 0 1 00 12 13 00000010
00826962 1 0 1 0 0 0 1 00 12 13 00000010
00826963 1 0 1 0 0 0 1 00 12 13 00000010
00826964 1 0 1 0 0 0 1 00 12 13 00000010
00826965 1 0 1 0 0 0 1 00 12 13 00000010
FF826966 1 0 1 0 0 0 1 00 12 13 FFFFFFF0
FF826967 1 0 1 0 0 0 1 00 12 13 FFFFFFF0
FF826968 1 0 1 0 0 0 1 00 12 13 FFFFFFF0
FF826969 1 0 1 0 0 0 1 00 12 13 FFFFFFF0
010C5182 1 1 0 1 0 0 0 23 22 21 00000000
0000000B 1 1 0 0 0 0 0 00 00 00 00000000
7FF92440 1 1 0 1 1 0 1 08 09 00 00000FFF
55E54A84 1 0 0 1 0 0 1 15 2A 00 00000ABC
DEADBEEF 0 0 0 0 0 0 0 00 00 00 00000000
FF816550 1 0 0 0 0 1 1 00 0A 0B FFFFFFF0
00000000 0 0 1 0 0 0 0 00 00 00 00000000

//--- verilog.f
source/decodePkg.sv
source/decodeBus.sv
source/decodeFlowCtrl.sv
source/decodeRegFields.sv
source/decodeImmediate.sv
source/decodeStageReg.sv
source/decodeUnit.sv
tests/decodeUnitTb.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the decode stage testbench with Verilator, runs it and scans the log
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f verilog.f --top-module decodeUnitTb -o decodeUnitSim

./obj_dir/decodeUnitSim | tee sim.log

if grep -q "Test failed" sim.log; then
	echo "Simulation reported a failure"
	exit 1
fi

echo "Simulation passed"

//--- tests/decodeUnitTb.sv
// Decode stage testbench
// Replays the trace through the decode unit and checks every registered record
`timescale 1ns/100ps

module decodeUnitTb;

	localparam int clkPeriod = 40;
	localparam int maxCycles = 200;

	logic clk;
	logic reset;
	logic [31:0] instr;
	logic instrValid;
	logic stall;
	logic decValid;
	logic fc;
	logic rfw;
	logic isLoad;
	logic isStore;
	logic hasImm;
	decodePkg::regNum_t Rt;
	decodePkg::regNum_t Ra;
	decodePkg::regNum_t Rb;
	logic [31:0] imm;

	// Field order shared by the trace columns and the model arrays
	string fieldNames [0:8] = '{"fc", "rfw", "isLoad", "isStore", "hasImm",
		"Rt", "Ra", "Rb", "imm"};

	// ==================================================
	// Reference model state
	// ==================================================

	// Decode of the current trace line as the trace states it
	logic [31:0] lineRecord [0:8];
	// Inputs driven one edge ago that the DUT samples on the next edge
	logic [31:0] heldRecord [0:8];
	logic heldValid;
	logic heldStall;
	// What the stage register should show right now
	logic [31:0] expRecord [0:8];
	logic expDecValid;
	int checkCount;
	int errorCount;
	int cycleCount;

	decodeUnit #(.dataWidth(32)) i_dut
	(
		.clk(clk),
		.reset(reset),
		.instr(instr),
		.instrValid(instrValid),
		.stall(stall),
		.decValid(decValid),
		.fc(fc),
		.rfw(rfw),
		.isLoad(isLoad),
		.isStore(isStore),
		.hasImm(hasImm),
		.Rt(Rt),
		.Ra(Ra),
		.Rb(Rb),
		.imm(imm)
	);

	initial
	begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	task automatic checkValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checkCount++;
		if (actual !== expected)
		begin
			errorCount++;
			$display("ERR %0t %s expected %h actual %h", $time, name, expected, actual);
		end
	endtask

	task automatic checkOutputs();
		logic [31:0] actual [0:8];
		actual[0] = 32'(fc);
		actual[1] = 32'(rfw);
		actual[2] = 32'(isLoad);
		actual[3] = 32'(isStore);
		actual[4] = 32'(hasImm);
		actual[5] = 32'(Rt);
		actual[6] = 32'(Ra);
		actual[7] = 32'(Rb);
		actual[8] = imm;
		checkValue("decValid", 32'(expDecValid), 32'(decValid));
		for (int i = 0; i < 9; i++)
			checkValue(fieldNames[i], expRecord[i], actual[i]);
	endtask

	// Each clock step drives new inputs, advances the model and then looks at the outputs
	task automatic runCycle(input logic [31:0] word, input logic validIn,
		input logic stallIn);
		@(posedge clk);
		instr <= word;
		instrValid <= validIn;
		stall <= stallIn;
		// This edge took the inputs of the previous step
		// A stalled edge freezes both the valid bit and the record
		if (!heldStall)
		begin
			expDecValid = heldValid;
			if (heldValid)
				expRecord = heldRecord;
		end
		heldValid = validIn;
		heldStall = stallIn;
		heldRecord = lineRecord;
		@(negedge clk);
		checkOutputs();
		cycleCount++;
	endtask

	// ==================================================
	// Main sequence
	// ==================================================

	initial
	begin
		int fd;
		int code;
		string line;
		logic [31:0] word;
		logic [31:0] validField;
		logic [31:0] stallField;
		checkCount = 0;
		errorCount = 0;
		cycleCount = 0;
		reset = 1'b1;
		instr = '0;
		instrValid = 1'b0;
		stall = 1'b0;
		heldValid = 1'b0;
		heldStall = 1'b0;
		expDecValid = 1'b0;
		word = '0;
		for (int i = 0; i < 9; i++)
		begin
			lineRecord[i] = '0;
			heldRecord[i] = '0;
			expRecord[i] = '0;
		end

		// Reset spans eight rising edges before the empty stage is checked
		repeat (8) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		checkOutputs();

		fd = $fopen("tests/decodeTrace.txt", "r");
		if (fd == 0)
		begin
			$display("Could not open the trace file tests/decodeTrace.txt");
			errorCount++;
		end
		else
		begin
			while (!$feof(fd) && cycleCount < maxCycles)
			begin
				code = $fgets(line, fd);
				if (code > 0)
				begin
					code = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h",
						word, validField, stallField,
						lineRecord[0], lineRecord[1], lineRecord[2], lineRecord[3],
						lineRecord[4], lineRecord[5], lineRecord[6], lineRecord[7],
						lineRecord[8]);
					if (code == 12)
						runCycle(word, validField[0], stallField[0]);
					else if (line.len() > 1 && line.getc(0) != "#")
					begin
						$display("Malformed trace line: %s", line);
						errorCount++;
					end
				end
			end
			if (!$feof(fd))
			begin
				$display("Trace did not finish within %0d cycles", maxCycles);
				errorCount++;
			end
			$fclose(fd);
			// An idle step pushes the last trace line through the register
			runCycle(32'h0000000B, 1'b0, 1'b0);
			// The last trace word is offered again to an empty stage under stall
			// and decValid has to stay low until the stall drops
			runCycle(word, 1'b1, 1'b1);
			runCycle(word, 1'b1, 1'b1);
			runCycle(word, 1'b1, 1'b0);
			runCycle(32'h0000000B, 1'b0, 1'b0);
			runCycle(32'h0000000B, 1'b0, 1'b0);
		end

		$display("Checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

	// Guard against a hung run
	initial
	begin
		#((maxCycles + 40) * clkPeriod);
		$display("Simulation timed out before the trace was done");
		$display("Test failed");
		$finish;
	end

endmodule

//--- source/decodeUnit.sv
// Instruction decode stage
// Splits the fetched word into a decoded record and registers it for one cycle
`timescale 1ns/100ps

module decodeUnit #(
	parameter int dataWidth = 32
)
(
	input logic clk,
	input logic reset,
	input logic [31:0] instr,
	input logic instrValid,
	input logic stall,
	output logic decValid,
	output logic fc,
	output logic rfw,
	output logic isLoad,
	output logic isStore,
	output logic hasImm,
	output decodePkg::regNum_t Rt,
	output decodePkg::regNum_t Ra,
	output decodePkg::regNum_t Rb,
	output logic [dataWidth-1:0] imm
);

	// Same bits, now visible through every format view
	decodePkg::instruction_t instrWord;

	assign instrWord = decodePkg::instruction_t'(instr);

	// Combinational record shared by the three field decoders
	decodeBus #(.dataWidth(dataWidth)) decBus();

	decodeFlowCtrl uFlowCtrl
	(
		.instr(instrWord),
		.dec(decBus.producer)
	);

	decodeRegFields uRegFields
	(
		.instr(instrWord),
		.dec(decBus.producer)
	);

	decodeImmediate #(.dataWidth(dataWidth)) uImmediate
	(
		.instr(instrWord),
		.dec(decBus.producer)
	);

	decodeStageReg #(.dataWidth(dataWidth)) uStageReg
	(
		.clk(clk),
		.reset(reset),
		.instrValid(instrValid),
		.stall(stall),
		.dec(decBus.consumer),
		.decValid(decValid),
		.fc(fc),
		.rfw(rfw),
		.isLoad(isLoad),
		.isStore(isStore),
		.hasImm(hasImm),
		.Rt(Rt),
		.Ra(Ra),
		.Rb(Rb),
		.imm(imm)
	);

endmodule

//--- source/decodeStageReg.sv
// Decode pipeline register
// Holds one decoded record for the next stage with valid and stall handling
`timescale 1ns/100ps

module decodeStageReg #(
	parameter int dataWidth = 32
)
(
	input logic clk,
	input logic reset,
	input logic instrValid,
	input logic stall,
	decodeBus.consumer dec,
	output logic decValid,
	output logic fc,
	output logic rfw,
	output logic isLoad,
	output logic isStore,
	output logic hasImm,
	output decodePkg::regNum_t Rt,
	output decodePkg::regNum_t Ra,
	output decodePkg::regNum_t Rb,
	output logic [dataWidth-1:0] imm
);

	// A new record is taken only when the fetch side offers one
	// and the stage is free to move
	logic capture;

	assign capture = instrValid && !stall;

	// ==================================================
	// Valid bit
	// ==================================================

	// Follows instrValid on every free edge so an idle cycle drops it,
	// while a stall freezes it together with the record
	always_ff @(posedge clk)
	begin
		if (reset)
			decValid <= 1'b0;
		else if (!stall)
			decValid <= instrValid;
	end

	// ==================================================
	// Record
	// ==================================================

	// The record only changes on an edge that captures a new instruction
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			fc <= 1'b0;
			rfw <= 1'b0;
			isLoad <= 1'b0;
			isStore <= 1'b0;
			hasImm <= 1'b0;
			Rt <= '0;
			Ra <= '0;
			Rb <= '0;
			imm <= '0;
		end
		else if (capture)
		begin
			fc <= dec.fc;
			rfw <= dec.rfw;
			isLoad <= dec.isLoad;
			isStore <= dec.isStore;
			hasImm <= dec.hasImm;
			Rt <= dec.Rt;
			Ra <= dec.Ra;
			Rb <= dec.Rb;
			imm <= dec.imm;
		end
	end

endmodule

//--- source/decodeImmediate.sv
// Immediate decoder
// Picks the immediate or displacement field and sign-extends it to the data width
`timescale 1ns/100ps

module decodeImmediate #(
	parameter int dataWidth = 32
)
(
	input decodePkg::instruction_t instr,
	decodeBus.producer dec
);

	localparam int fieldWidth = decodePkg::immFieldWidth;

	logic [fieldWidth-1:0] field;
	logic present;

	always_comb
	begin
		field = '0;
		present = 1'b0;
		case (instr.any.opcode)
			// Immediate format ALU ops and load offsets
			decodePkg::OP_ADDI, decodePkg::OP_ANDI,
			decodePkg::OP_ORI, decodePkg::OP_LOAD:
			begin
				field = instr.immFmt.imm;
				present = 1'b1;
			end
			// Store offset and every branch displacement share one slot
			// JSR and BSR keep their displacement in the same bits
			decodePkg::OP_STORE,
			decodePkg::OP_JSR, decodePkg::OP_BSR, decodePkg::OP_RTD,
			decodePkg::OP_DBRA,
			decodePkg::OP_BEQ, decodePkg::OP_BNE,
			decodePkg::OP_BLT, decodePkg::OP_BLE,
			decodePkg::OP_BGE, decodePkg::OP_BGT,
			decodePkg::OP_BBC, decodePkg::OP_BBS,
			decodePkg::OP_BBCI, decodePkg::OP_BBSI:
			begin
				field = instr.brFmt.disp;
				present = 1'b1;
			end
			// ALU register format, SYS and NOP carry no constant
			default:
			begin
				field = '0;
				present = 1'b0;
			end
		endcase
	end

	// Replicate the top bit of the field over the upper part of the word
	assign dec.imm = {{(dataWidth-fieldWidth){field[fieldWidth-1]}}, field};
	assign dec.hasImm = present;

endmodule

//--- source/decodeRegFields.sv
// Register field decoder
// Routes Rt, Ra and Rb per format and raises the write, load and store flags
`timescale 1ns/100ps

module decodeRegFields
(
	input decodePkg::instruction_t instr,
	decodeBus.producer dec
);

	decodePkg::regNum_t rtSel;
	decodePkg::regNum_t raSel;
	decodePkg::regNum_t rbSel;
	logic rfwSel;
	logic loadSel;
	logic storeSel;

	always_comb
	begin
		// Anything the format does not name reads back as zero
		rtSel = '0;
		raSel = '0;
		rbSel = '0;
		rfwSel = 1'b0;
		loadSel = 1'b0;
		storeSel = 1'b0;
		case (instr.any.opcode)
			decodePkg::OP_ALU:
			begin
				rtSel = instr.regFmt.Rt;
				raSel = instr.regFmt.Ra;
				rbSel = instr.regFmt.Rb;
				rfwSel = 1'b1;
			end
			decodePkg::OP_ADDI, decodePkg::OP_ANDI, decodePkg::OP_ORI:
			begin
				rtSel = instr.immFmt.Rt;
				raSel = instr.immFmt.Ra;
				rfwSel = 1'b1;
			end
			decodePkg::OP_LOAD:
			begin
				rtSel = instr.immFmt.Rt;
				raSel = instr.immFmt.Ra;
				rfwSel = 1'b1;
				loadSel = 1'b1;
			end
			// Base in Ra and store data in Rb, nothing written back
			decodePkg::OP_STORE:
			begin
				raSel = instr.brFmt.Ra;
				rbSel = instr.brFmt.Rb;
				storeSel = 1'b1;
			end
			// Link register in bits 12 to 7, JSR also takes a target base in Ra
			decodePkg::OP_JSR:
			begin
				rtSel = instr.immFmt.Rt;
				raSel = instr.immFmt.Ra;
				rfwSel = 1'b1;
			end
			// BSR is PC relative and only needs the link register
			decodePkg::OP_BSR:
			begin
				rtSel = instr.immFmt.Rt;
				rfwSel = 1'b1;
			end
			decodePkg::OP_DBRA, decodePkg::OP_RTD,
			decodePkg::OP_BEQ, decodePkg::OP_BNE,
			decodePkg::OP_BLT, decodePkg::OP_BLE,
			decodePkg::OP_BGE, decodePkg::OP_BGT,
			decodePkg::OP_BBC, decodePkg::OP_BBS,
			decodePkg::OP_BBCI, decodePkg::OP_BBSI:
			begin
				raSel = instr.brFmt.Ra;
				rbSel = instr.brFmt.Rb;
			end
			// SYS, NOP and unknown opcodes keep the all-zero defaults
			default:
			begin
			end
		endcase
	end

	assign dec.Rt = rtSel;
	assign dec.Ra = raSel;
	assign dec.Rb = rbSel;
	assign dec.rfw = rfwSel;
	assign dec.isLoad = loadSel;
	assign dec.isStore = storeSel;

endmodule

//--- source/decodeFlowCtrl.sv
// Flow-control decoder
// Flags every opcode that may redirect the program counter
`timescale 1ns/100ps

module decodeFlowCtrl
(
	input decodePkg::instruction_t instr,
	decodeBus.producer dec
);

	// Only the opcode matters here so the any view is enough
	function automatic logic isFlowCtrl(input decodePkg::instruction_t ir);
		logic result;
		result = 1'b0;
		case (ir.any.opcode)
			// System calls trap away from the current stream
			decodePkg::OP_SYS,
			decodePkg::OP_JSR:
				result = 1'b1;
			// Conditional branches and the decrement loop
			decodePkg::OP_DBRA,
			decodePkg::OP_BEQ, decodePkg::OP_BNE,
			decodePkg::OP_BLT, decodePkg::OP_BLE,
			decodePkg::OP_BGE, decodePkg::OP_BGT:
				result = 1'b1;
			// Bit test branches, register and immediate bit number
			decodePkg::OP_BBC, decodePkg::OP_BBS,
			decodePkg::OP_BBCI, decodePkg::OP_BBSI:
				result = 1'b1;
			// Subroutine call and return
			decodePkg::OP_BSR,
			decodePkg::OP_RTD:
				result = 1'b1;
			default:
				result = 1'b0;
		endcase
		return result;
	endfunction

	assign dec.fc = isFlowCtrl(instr);

endmodule

//--- source/decodeBus.sv
// Decoded record bus
// Carries one decoded instruction from the field decoders to the stage register
`timescale 1ns/100ps

interface decodeBus #(
	parameter int dataWidth = 32
);

	// Classification flags
	logic fc;
	logic rfw;
	logic isLoad;
	logic isStore;
	logic hasImm;

	// Register numbers, zero when the format has no such field
	decodePkg::regNum_t Rt;
	decodePkg::regNum_t Ra;
	decodePkg::regNum_t Rb;

	// Sign-extended immediate or displacement
	logic [dataWidth-1:0] imm;

	// Each decoder drives its own disjoint subset of these
	modport producer
	(
		output fc, rfw, isLoad, isStore, hasImm,
		output Rt, Ra, Rb,
		output imm
	);

	modport consumer
	(
		input fc, rfw, isLoad, isStore, hasImm,
		input Rt, Ra, Rb,
		input imm
	);

endinterface

//--- source/decodePkg.sv
// Decode stage definitions
// Opcode map, register number type and the instruction word with its format views

package decodePkg;

	// ==================================================
	// Field sizes
	// ==================================================

	// Immediate and displacement fields are both 13 bits wide
	parameter int immFieldWidth = 13;

	// 64 architectural registers
	typedef logic [5:0] regNum_t;

	// ==================================================
	// Major opcodes
	// ==================================================

	// The flow-control group sits in one block near the top of the map
	// so that the whole range can be told apart at a glance in a dump
	typedef enum logic [6:0]
	{
		OP_SYS   = 7'h00,
		OP_ALU   = 7'h02,
		OP_JSR   = 7'h03,
		OP_ADDI  = 7'h04,
		OP_ANDI  = 7'h08,
		OP_ORI   = 7'h09,
		OP_NOP   = 7'h0B,
		OP_LOAD  = 7'h40,
		OP_STORE = 7'h50,
		OP_DBRA  = 7'h5F,
		OP_BEQ   = 7'h60,
		OP_BNE   = 7'h61,
		OP_BLT   = 7'h62,
		OP_BLE   = 7'h63,
		OP_BGE   = 7'h64,
		OP_BGT   = 7'h65,
		OP_BBC   = 7'h66,
		OP_BBS   = 7'h67,
		OP_BBCI  = 7'h68,
		OP_BBSI  = 7'h69,
		OP_BSR   = 7'h6A,
		OP_RTD   = 7'h6B
	} opcode_t;

	// ==================================================
	// Instruction formats
	// ==================================================

	// Opcode only, the rest of the word left for the format views
	typedef struct packed
	{
		logic [24:0] payload;
		opcode_t opcode;
	} anyFmt_t;

	// Register to register ALU operations
	typedef struct packed
	{
		logic [6:0] func;
		regNum_t Rb;
		regNum_t Ra;
		regNum_t Rt;
		opcode_t opcode;
	} regFmt_t;

	// Immediate ALU operations and loads
	// JSR and BSR also use this layout, the link register sits in Rt
	typedef struct packed
	{
		logic [immFieldWidth-1:0] imm;
		regNum_t Ra;
		regNum_t Rt;
		opcode_t opcode;
	} immFmt_t;

	// Branches and stores
	// For a store Rb names the data register and Ra the base
	typedef struct packed
	{
		logic [immFieldWidth-1:0] disp;
		regNum_t Rb;
		regNum_t Ra;
		opcode_t opcode;
	} brFmt_t;

	// One 32-bit word seen through every format at once
	// The opcode lands in bits 6 to 0 in all views
	typedef union packed
	{
		anyFmt_t any;
		regFmt_t regFmt;
		immFmt_t immFmt;
		brFmt_t brFmt;
	} instruction_t;

endpackage
